//--- source/rv_pkg.sv
package rv_pkg;

    // Data, address and instruction word.
    typedef logic [31:0] word_t;

    // One transfer on the external bus.
    typedef logic [15:0] half_t;

    typedef logic [4:0] reg_idx_t;

    // Same encoding as funct3[1:0] of loads and stores.
    typedef logic [1:0] mem_size_t;

    localparam mem_size_t SIZE_BYTE = 2'd0;
    localparam mem_size_t SIZE_HALF = 2'd1;
    localparam mem_size_t SIZE_WORD = 2'd2;

    // Major opcodes of RV32I.
    localparam logic [6:0] OP_LUI     = 7'b0110111;
    localparam logic [6:0] OP_AUIPC   = 7'b0010111;
    localparam logic [6:0] OP_JAL     = 7'b1101111;
    localparam logic [6:0] OP_JALR    = 7'b1100111;
    localparam logic [6:0] OP_BRANCH  = 7'b1100011;
    localparam logic [6:0] OP_LOAD    = 7'b0000011;
    localparam logic [6:0] OP_STORE   = 7'b0100011;
    localparam logic [6:0] OP_ALU_IMM = 7'b0010011;
    localparam logic [6:0] OP_ALU_REG = 7'b0110011;

    typedef enum logic [2:0] {
        fetch,
        exec,
        load_wait,
        store_wait,
        writeback_load
    } core_state_e;

    typedef enum logic [2:0] {
        idle,
        addr_lo,
        addr_hi,
        data_lo,
        addr_lo2,
        data_hi,
        done
    } bus_state_e;

endpackage

//--- source/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
    input  logic             clk,
    input  rv_pkg::reg_idx_t rs1_idx,
    input  rv_pkg::reg_idx_t rs2_idx,
    output rv_pkg::word_t    rs1_val,
    output rv_pkg::word_t    rs2_val,
    input  logic             rd_we,
    input  rv_pkg::reg_idx_t rd_idx,
    input  rv_pkg::word_t    rd_val
);
    import rv_pkg::*;

    word_t regs [0:31];

    // Entry 0 is never written.
    always_ff @(posedge clk) begin
        if (rd_we && (rd_idx != '0)) begin
            regs[rd_idx] <= rd_val;
        end
    end

    assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

//--- source/rv_alu.sv
`timescale 1ns/10ps

module rv_alu (
    input  rv_pkg::word_t alu_a,
    input  rv_pkg::word_t alu_b,
    input  logic [2:0]    funct3,
    input  logic          alt,
    input  logic          is_reg,
    output rv_pkg::word_t alu_result,
    output logic          take_branch
);
    import rv_pkg::*;

    word_t       sum;
    logic [32:0] diff;
    word_t       x_or;
    logic        eq;
    logic        lt_u;
    logic        lt_s;
    word_t       shift_in;
    logic        shift_fill;
    logic [32:0] shift_wide;
    word_t       shift_out;

    function automatic word_t bit_reverse(input word_t v);
        word_t r;
        for (int i = 0; i < 32; i++) begin
            r[i] = v[31 - i];
        end
        return r;
    endfunction

    assign sum  = alu_a + alu_b;
    assign diff = {1'b0, alu_a} - {1'b0, alu_b};
    assign x_or = alu_a ^ alu_b;
    assign eq   = (x_or == '0);

    // Borrow out of the subtraction gives the unsigned compare.
    assign lt_u = diff[32];
    assign lt_s = (alu_a[31] ^ alu_b[31]) ? alu_a[31] : diff[32];

    // Left shifts reuse the right shifter on a reversed operand.
    assign shift_in   = (funct3 == 3'b001) ? bit_reverse(alu_a) : alu_a;
    assign shift_fill = alt && (funct3 == 3'b101) && alu_a[31];
    assign shift_wide = $signed({shift_fill, shift_in}) >>> alu_b[4:0];
    assign shift_out  = shift_wide[31:0];

    always_comb begin
        case (funct3)
            3'b000: begin
                // Only SUB, never ADDI with a negative immediate.
                if (is_reg && alt) begin
                    alu_result = diff[31:0];
                end else begin
                    alu_result = sum;
                end
            end
            3'b001: begin
                alu_result = bit_reverse(shift_out);
            end
            3'b010: begin
                alu_result = {31'd0, lt_s};
            end
            3'b011: begin
                alu_result = {31'd0, lt_u};
            end
            3'b100: begin
                alu_result = x_or;
            end
            3'b101: begin
                alu_result = shift_out;
            end
            3'b110: begin
                alu_result = alu_a | alu_b;
            end
            default: begin
                alu_result = alu_a & alu_b;
            end
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000: take_branch = eq;
            3'b001: take_branch = !eq;
            3'b100: take_branch = lt_s;
            3'b101: take_branch = !lt_s;
            3'b110: take_branch = lt_u;
            3'b111: take_branch = !lt_u;
            default: take_branch = 1'b0;
        endcase
    end

endmodule

//--- source/rv_bus_seq.sv
`timescale 1ns/10ps

module rv_bus_seq (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mem_req,
    input  rv_pkg::word_t     mem_addr,
    input  rv_pkg::mem_size_t mem_size,
    input  logic              mem_write,
    input  rv_pkg::word_t     mem_wdata,
    output logic              mem_ack,
    output rv_pkg::word_t     mem_rdata,
    output rv_pkg::half_t     bus_out,
    input  rv_pkg::half_t     bus_in,
    output logic              le_lo,
    output logic              le_hi,
    output logic              oe_n,
    output logic              we_lo_n,
    output logic              we_hi_n,
    output logic              bus_dir
);
    import rv_pkg::*;

    bus_state_e state;
    logic       data_phase;
    logic       is_byte;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (mem_req) begin
                        state <= addr_lo;
                    end
                end
                addr_lo:  state <= addr_hi;
                addr_hi:  state <= data_lo;
                data_lo:  state <= (mem_size == SIZE_WORD) ? addr_lo2 : done;
                addr_lo2: state <= data_hi;
                data_hi:  state <= done;
                done: begin
                    // Hold the ack until the core lets go of the request.
                    if (!mem_req) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Read halves are taken at the edge that closes each data phase.
    always_ff @(posedge clk) begin
        if (state == data_lo && !mem_write) begin
            if (is_byte) begin
                mem_rdata <= {24'd0, mem_addr[0] ? bus_in[15:8] : bus_in[7:0]};
            end else begin
                mem_rdata <= {16'd0, bus_in};
            end
        end else if (state == data_hi && !mem_write) begin
            mem_rdata[31:16] <= bus_in;
        end
    end

    always_comb begin
        case (state)
            addr_lo:  bus_out = mem_addr[16:1];
            addr_hi:  bus_out = {1'b0, mem_addr[31:17]};
            data_lo: begin
                if (is_byte) begin
                    bus_out = mem_addr[0] ? {mem_wdata[7:0], 8'h00} : {8'h00, mem_wdata[7:0]};
                end else begin
                    bus_out = mem_wdata[15:0];
                end
            end
            addr_lo2: bus_out = mem_addr[16:1] | 16'h0001;
            data_hi:  bus_out = mem_wdata[31:16];
            default:  bus_out = 16'h0000;
        endcase
    end

    assign is_byte    = (mem_size == SIZE_BYTE);
    assign data_phase = (state == data_lo) || (state == data_hi);

    assign mem_ack = (state == done);
    assign le_lo   = (state == addr_lo) || (state == addr_lo2);
    assign le_hi   = (state == addr_hi);
    assign oe_n    = !(data_phase && !mem_write);

    // A byte write enables only the lane picked by address bit 0.
    assign we_lo_n = !(data_phase && mem_write && (!is_byte || !mem_addr[0]));
    assign we_hi_n = !(data_phase && mem_write && (!is_byte || mem_addr[0]));
    assign bus_dir = !(le_lo || le_hi || (data_phase && mem_write));

endmodule

//--- source/rv_core_ctrl.sv
`timescale 1ns/10ps

module rv_core_ctrl #(
    parameter rv_pkg::word_t reset_pc = '0
) (
    input  logic              clk,
    input  logic              rst_n,
    output logic              mem_req,
    output rv_pkg::word_t     mem_addr,
    output rv_pkg::mem_size_t mem_size,
    output logic              mem_write,
    output rv_pkg::word_t     mem_wdata,
    input  logic              mem_ack,
    input  rv_pkg::word_t     mem_rdata,
    output rv_pkg::reg_idx_t  rs1_idx,
    output rv_pkg::reg_idx_t  rs2_idx,
    input  rv_pkg::word_t     rs1_val,
    input  rv_pkg::word_t     rs2_val,
    output rv_pkg::word_t     alu_a,
    output rv_pkg::word_t     alu_b,
    output logic [2:0]        funct3,
    output logic              alt,
    output logic              is_reg,
    input  rv_pkg::word_t     alu_result,
    input  logic              take_branch,
    output logic              rd_we,
    output rv_pkg::reg_idx_t  rd_idx,
    output rv_pkg::word_t     rd_val
);
    import rv_pkg::*;

    core_state_e state;
    word_t       pc;
    word_t       ir;
    word_t       ld_data;
    logic [2:0]  ir_funct3;
    logic        is_lui, is_auipc, is_jal, is_jalr, is_branch;
    logic        is_load, is_store, is_alu_imm, is_alu_reg;
    word_t       i_imm, s_imm, b_imm, u_imm, j_imm;
    word_t       pc_plus4;
    logic        bus_wait;
    logic        req_start;
    logic        xfer_done;
    logic        ld_sign;

    assign ir_funct3  = ir[14:12];
    assign is_lui     = (ir[6:0] == OP_LUI);
    assign is_auipc   = (ir[6:0] == OP_AUIPC);
    assign is_jal     = (ir[6:0] == OP_JAL);
    assign is_jalr    = (ir[6:0] == OP_JALR);
    assign is_branch  = (ir[6:0] == OP_BRANCH);
    assign is_load    = (ir[6:0] == OP_LOAD);
    assign is_store   = (ir[6:0] == OP_STORE);
    assign is_alu_imm = (ir[6:0] == OP_ALU_IMM);
    assign is_alu_reg = (ir[6:0] == OP_ALU_REG);

    assign i_imm = {{21{ir[31]}}, ir[30:20]};
    assign s_imm = {{21{ir[31]}}, ir[30:25], ir[11:7]};
    assign b_imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
    assign u_imm = {ir[31:12], 12'h000};
    assign j_imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

    assign pc_plus4 = pc + 32'd4;
    assign rs1_idx  = ir[19:15];
    assign rs2_idx  = ir[24:20];

    // Address and jump arithmetic all runs as a plain add.
    assign alu_a  = is_jal ? pc : rs1_val;
    assign alu_b  = is_jal ? j_imm :
                    is_store ? s_imm :
                    (is_alu_reg || is_branch) ? rs2_val : i_imm;
    assign funct3 = (is_alu_reg || is_alu_imm || is_branch) ? ir_funct3 : 3'b000;
    assign alt    = ir[30];
    assign is_reg = is_alu_reg;

    assign bus_wait  = (state == fetch) || (state == load_wait) || (state == store_wait);
    assign req_start = bus_wait && !mem_req && !mem_ack;
    assign xfer_done = mem_req && mem_ack;

    assign ld_sign = !ir_funct3[2] &&
                     ((ir_funct3[1:0] == SIZE_BYTE) ? ld_data[7] : ld_data[15]);

    assign rd_idx = ir[11:7];
    assign rd_we  = (state == writeback_load) ||
                    ((state == exec) &&
                     (is_lui || is_auipc || is_jal || is_jalr || is_alu_imm || is_alu_reg));

    always_comb begin
        if (state == writeback_load) begin
            case (ir_funct3[1:0])
                SIZE_BYTE: rd_val = {{24{ld_sign}}, ld_data[7:0]};
                SIZE_HALF: rd_val = {{16{ld_sign}}, ld_data[15:0]};
                default:   rd_val = ld_data;
            endcase
        end else if (is_lui) begin
            rd_val = u_imm;
        end else if (is_auipc) begin
            rd_val = pc + u_imm;
        end else if (is_jal || is_jalr) begin
            rd_val = pc_plus4;
        end else begin
            rd_val = alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= fetch;
            pc      <= reset_pc;
            mem_req <= 1'b0;
        end else begin
            if (req_start) begin
                mem_req <= 1'b1;
            end else if (xfer_done) begin
                mem_req <= 1'b0;
            end
            case (state)
                fetch: begin
                    if (xfer_done) begin
                        state <= exec;
                    end
                end
                exec: begin
                    if (is_jal) begin
                        pc <= alu_result;
                    end else if (is_jalr) begin
                        pc <= {alu_result[31:1], 1'b0};
                    end else if (is_branch && take_branch) begin
                        pc <= pc + b_imm;
                    end else begin
                        pc <= pc_plus4;
                    end
                    if (is_load) begin
                        state <= load_wait;
                    end else if (is_store) begin
                        state <= store_wait;
                    end else begin
                        state <= fetch;
                    end
                end
                load_wait: begin
                    if (xfer_done) begin
                        state <= writeback_load;
                    end
                end
                store_wait: begin
                    if (xfer_done) begin
                        state <= fetch;
                    end
                end
                default: state <= fetch;
            endcase
        end
    end

    // Request fields stay put while mem_req is high.
    always_ff @(posedge clk) begin
        if (state == fetch && req_start) begin
            mem_addr  <= pc;
            mem_size  <= SIZE_WORD;
            mem_write <= 1'b0;
        end else if (state == exec) begin
            mem_addr  <= alu_result;
            mem_size  <= ir_funct3[1:0];
            mem_write <= is_store;
            mem_wdata <= rs2_val;
        end
        if (state == fetch && xfer_done) begin
            ir <= mem_rdata;
        end
        if (state == load_wait && xfer_done) begin
            ld_data <= mem_rdata;
        end
    end

endmodule

//--- source/rv_top.sv
`timescale 1ns/10ps

module rv_top #(
    parameter rv_pkg::word_t reset_pc = '0
) (
    input  logic          clk,
    input  logic          rst_n,
    output rv_pkg::half_t bus_out,
    input  rv_pkg::half_t bus_in,
    output logic          le_lo,
    output logic          le_hi,
    output logic          oe_n,
    output logic          we_lo_n,
    output logic          we_hi_n,
    output logic          bus_dir
);
    import rv_pkg::*;

    logic      mem_req;
    word_t     mem_addr;
    mem_size_t mem_size;
    logic      mem_write;
    word_t     mem_wdata;
    logic      mem_ack;
    word_t     mem_rdata;
    reg_idx_t  rs1_idx;
    reg_idx_t  rs2_idx;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     alu_a;
    word_t     alu_b;
    logic [2:0] funct3;
    logic      alt;
    logic      is_reg;
    word_t     alu_result;
    logic      take_branch;
    logic      rd_we;
    reg_idx_t  rd_idx;
    word_t     rd_val;

    rv_core_ctrl #(
        .reset_pc(reset_pc)
    ) u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_size(mem_size),
        .mem_write(mem_write), .mem_wdata(mem_wdata),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .alu_a(alu_a), .alu_b(alu_b), .funct3(funct3), .alt(alt), .is_reg(is_reg),
        .alu_result(alu_result), .take_branch(take_branch),
        .rd_we(rd_we), .rd_idx(rd_idx), .rd_val(rd_val)
    );

    rv_regfile u_regfile (
        .clk(clk),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .rd_we(rd_we), .rd_idx(rd_idx), .rd_val(rd_val)
    );

    rv_alu u_alu (
        .alu_a(alu_a), .alu_b(alu_b), .funct3(funct3), .alt(alt), .is_reg(is_reg),
        .alu_result(alu_result), .take_branch(take_branch)
    );

    rv_bus_seq u_bus (
        .clk(clk), .rst_n(rst_n),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_size(mem_size),
        .mem_write(mem_write), .mem_wdata(mem_wdata),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .bus_out(bus_out), .bus_in(bus_in), .le_lo(le_lo), .le_hi(le_hi),
        .oe_n(oe_n), .we_lo_n(we_lo_n), .we_hi_n(we_hi_n), .bus_dir(bus_dir)
    );

endmodule

//--- dv/rv_bus_assert.sv
`timescale 1ns/10ps

module rv_bus_assert (
    input logic clk,
    input logic rst_n,
    input logic mem_req,
    input logic mem_ack,
    input logic le_lo,
    input logic le_hi,
    input logic oe_n,
    input logic we_lo_n,
    input logic we_hi_n
);
    int violations = 0;

    le_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(le_lo && le_hi))
        else begin
            violations++;
            $error("le_lo and le_hi high in the same cycle");
        end

    // A read and a write data phase never overlap.
    oe_we_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(!oe_n && (!we_lo_n || !we_hi_n)))
        else begin
            violations++;
            $error("oe_n low together with a write enable");
        end

    ack_rise: assert property (@(posedge clk) disable iff (!rst_n) $rose(mem_ack) |-> mem_req)
        else begin
            violations++;
            $error("mem_ack rose without mem_req");
        end

    ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(mem_ack) |-> !$past(mem_req))
        else begin
            violations++;
            $error("mem_ack fell while mem_req was still high");
        end

endmodule

bind rv_bus_seq rv_bus_assert u_bus_assert (
    .clk(clk), .rst_n(rst_n), .mem_req(mem_req), .mem_ack(mem_ack),
    .le_lo(le_lo), .le_hi(le_hi), .oe_n(oe_n), .we_lo_n(we_lo_n), .we_hi_n(we_hi_n)
);

//--- dv/rv_tb.sv
`timescale 1ns/10ps

module rv_tb;
    import rv_pkg::*;

    localparam word_t RESET_PC  = 32'h0000_0100;
    localparam word_t DATA_BASE = 32'h0000_0500;
    localparam word_t RES_BASE  = 32'h0000_0700;
    localparam word_t TRAP_ADDR = 32'h0000_07fc;

    logic  clk;
    logic  rst_n;
    half_t bus_out;
    half_t bus_in;
    logic  le_lo;
    logic  le_hi;
    logic  oe_n;
    logic  we_lo_n;
    logic  we_hi_n;
    logic  bus_dir;

    half_t       ram [0:65535];
    half_t       lat_lo;
    half_t       lat_hi;
    logic [16:0] latch_log [$];
    // Expected writes as {half-word address, lane enables, data}.
    logic [33:0] exp_q [$];
    word_t       lcg_state;
    word_t       asm_pc;
    word_t       res_ptr;
    int          n_instr;
    int          err_count;
    int          check_count;
    int          test_count;
    int          err_mark;
    int          check_mark;
    int          run_cycles;
    int          cycle_limit;
    string       test_name;

    rv_top #(
        .reset_pc(RESET_PC)
    ) uut (
        .clk(clk), .rst_n(rst_n), .bus_out(bus_out), .bus_in(bus_in),
        .le_lo(le_lo), .le_hi(le_hi), .oe_n(oe_n),
        .we_lo_n(we_lo_n), .we_hi_n(we_hi_n), .bus_dir(bus_dir)
    );

    always #2 clk = ~clk;

    // External RAM, addressed in half-words through the two latches.
    always @(posedge clk) begin
        if (le_lo) begin
            lat_lo <= bus_out;
        end
        if (le_hi) begin
            lat_hi <= bus_out;
        end
        if (!we_lo_n) begin
            ram[lat_lo][7:0] <= bus_out[7:0];
        end
        if (!we_hi_n) begin
            ram[lat_lo][15:8] <= bus_out[15:8];
        end
        if (rst_n && le_lo) begin
            latch_log.push_back({1'b0, bus_out});
        end
        if (rst_n && le_hi) begin
            latch_log.push_back({1'b1, bus_out});
        end
    end

    always @(negedge clk) begin
        bus_in <= oe_n ? 16'h0000 : ram[lat_lo];
    end

    task automatic mismatch(input string sig, input word_t got, input word_t expd);
        $display("FAIL t=%0t %s: got %h, expected %h", $time, sig, got, expd);
        err_count++;
    endtask

    task automatic check_level(input string sig, input logic got, input logic expd);
        if (got !== expd) begin
            mismatch(sig, got, expd);
        end
    endtask

    always @(posedge clk) begin : compare_writes
        logic [33:0] e;
        logic [1:0]  en;
        half_t       mask;
        if (rst_n && (!we_lo_n || !we_hi_n) && lat_hi == 16'h0000 &&
            lat_lo[15:7] == RES_BASE[16:8]) begin
            en = {!we_hi_n, !we_lo_n};
            check_count++;
            if (exp_q.size() == 0) begin
                $display("Unexpected write at %0t to half-word address %h", $time, lat_lo);
                err_count++;
            end else begin
                e = exp_q.pop_front();
                mask = {{8{e[17]}}, {8{e[16]}}};
                if (lat_lo !== e[33:18]) begin
                    mismatch("ram write address", lat_lo, e[33:18]);
                end else if (en !== e[17:16]) begin
                    mismatch("{we_hi, we_lo}", en, e[17:16]);
                end else if ((bus_out & mask) !== (e[15:0] & mask)) begin
                    mismatch("bus_out", bus_out, e[15:0]);
                end
            end
        end
    end

    // The pins only drive during address latches and write data.
    always @(posedge clk) begin : check_bus_dir
        logic exp_dir;
        if (rst_n) begin
            exp_dir = !(le_lo || le_hi || !we_lo_n || !we_hi_n);
            if (bus_dir !== exp_dir) begin
                mismatch("bus_dir", bus_dir, exp_dir);
            end
        end
    end

    // Each program adds its own budget to the limit.
    initial begin : watchdog
        while (run_cycles <= cycle_limit) begin
            @(posedge clk);
            if (rst_n) begin
                run_cycles++;
            end
        end
        $display("Timeout in %s: the core stopped making progress", test_name);
        $display("Some tests failed");
        $finish;
    end

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Op is {bit 30 of the instruction, funct3}.
    function automatic word_t alu_ref(input logic [3:0] op, input word_t a, input word_t b);
        word_t sra;
        sra = $signed(a) >>> b[4:0];
        case (op[2:0])
            3'd0: return op[3] ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return op[3] ? sra : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic word_t load_ext_ref(input mem_size_t size, input logic uns,
                                           input word_t raw);
        case (size)
            2'd0: return uns ? {24'd0, raw[7:0]} : {{24{raw[7]}}, raw[7:0]};
            2'd1: return uns ? {16'd0, raw[15:0]} : {{16{raw[15]}}, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OP_ALU_REG};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd,
                                     input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t b_type(input logic [12:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                     input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic word_t j_type(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    task automatic emit(input word_t ins);
        ram[asm_pc[16:1]] = ins[15:0];
        ram[asm_pc[16:1] + 16'd1] = ins[31:16];
        asm_pc = asm_pc + 32'd4;
        n_instr++;
    endtask

    task automatic load_const(input reg_idx_t rd, input word_t val);
        word_t upper;
        upper = val + 32'h800;
        emit(u_type(upper[31:12], rd, OP_LUI));
        emit(i_type(val[11:0], rd, 3'd0, rd, OP_ALU_IMM));
    endtask

    task automatic expect_write(input half_t idx, input logic [1:0] en, input half_t data);
        exp_q.push_back({idx, en, data});
    endtask

    task automatic expect_word(input word_t addr, input word_t val);
        expect_write(addr[16:1], 2'b11, val[15:0]);
        expect_write(addr[16:1] + 16'd1, 2'b11, val[31:16]);
    endtask

    task automatic store_result(input reg_idx_t src, input word_t expected);
        emit(s_type(res_ptr[11:0], src, 5'd0, 3'd2));
        expect_word(res_ptr, expected);
        res_ptr = res_ptr + 32'd4;
    endtask

    // Executed only if a jump or branch goes wrong.
    task automatic emit_trap();
        emit(s_type(TRAP_ADDR[11:0], 5'd0, 5'd0, 3'd2));
    endtask

    task automatic reset_core();
        err_mark = err_count;
        check_mark = check_count;
        @(negedge clk);
        rst_n = 1'b0;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            if (i >= 2) begin
                check_count++;
                check_level("le_lo", le_lo, 1'b0);
                check_level("le_hi", le_hi, 1'b0);
                check_level("oe_n", oe_n, 1'b1);
                check_level("we_lo_n", we_lo_n, 1'b1);
                check_level("we_hi_n", we_hi_n, 1'b1);
                check_level("bus_dir", bus_dir, 1'b1);
            end
        end
        for (int i = 0; i < 65536; i++) begin
            ram[i] = half_t'(i * 40503) ^ 16'h3c5a;
        end
        latch_log.delete();
        exp_q.delete();
        asm_pc = RESET_PC;
        res_ptr = RES_BASE;
        n_instr = 0;
    endtask

    task automatic wait_results(input string name);
        test_name = name;
        cycle_limit = cycle_limit + 20 * n_instr + 150;
        @(negedge clk);
        rst_n = 1'b1;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // Give stray writes a chance to show up.
        repeat (50) @(negedge clk);
    endtask

    task automatic report_test(input string name);
        test_count++;
        $display("%s: %0d checks, %0d errors", name, check_count - check_mark,
                 err_count - err_mark);
    endtask

    task automatic reset_behavior();
        word_t v;
        reset_core();
        v = next_rand();
        load_const(5'd5, v);
        store_result(5'd5, v);
        emit(j_type(21'd0, 5'd0));
        wait_results("reset_behavior");
        check_count++;
        if (latch_log.size() < 3) begin
            $display("Fewer than three address latches after reset release");
            err_count++;
        end else begin
            if (latch_log[0] !== {1'b0, RESET_PC[16:1]}) begin
                mismatch("first le_lo address", latch_log[0], {1'b0, RESET_PC[16:1]});
            end
            if (latch_log[1] !== {2'b10, RESET_PC[31:17]}) begin
                mismatch("first le_hi address", latch_log[1], {2'b10, RESET_PC[31:17]});
            end
            if (latch_log[2] !== {1'b0, RESET_PC[16:2], 1'b1}) begin
                mismatch("second le_lo address", latch_log[2], {1'b0, RESET_PC[16:2], 1'b1});
            end
        end
        report_test("reset_behavior");
    endtask

    task automatic alu_sweep();
        word_t       a;
        word_t       b;
        logic [11:0] imm;
        logic [3:0]  op;
        reset_core();
        for (int k = 0; k < 10; k++) begin
            op = (k < 8) ? {1'b0, 3'(k)} : ((k == 8) ? 4'b1000 : 4'b1101);
            a = next_rand();
            b = next_rand();
            load_const(5'd1, a);
            load_const(5'd2, b);
            emit(r_type({1'b0, op[3], 5'd0}, 5'd2, 5'd1, op[2:0], 5'd3));
            store_result(5'd3, alu_ref(op, a, b));
        end
        for (int k = 0; k < 9; k++) begin
            op = (k < 8) ? {1'b0, 3'(k)} : 4'b1101;
            a = next_rand();
            b = next_rand();
            if (op[1:0] == 2'b01) begin
                imm = {1'b0, op[3], 5'd0, b[4:0]};
            end else begin
                imm = b[11:0];
            end
            load_const(5'd1, a);
            emit(i_type(imm, 5'd1, op[2:0], 5'd3, OP_ALU_IMM));
            store_result(5'd3, alu_ref(op, a, {{20{imm[11]}}, imm}));
        end
        emit(j_type(21'd0, 5'd0));
        wait_results("alu_sweep");
        report_test("alu_sweep");
    endtask

    task automatic store_lane_cases();
        word_t v;
        word_t addr;
        reset_core();
        v = next_rand();
        load_const(5'd1, v);
        addr = RES_BASE;
        emit(s_type(addr[11:0], 5'd1, 5'd0, 3'd0));
        expect_write(addr[16:1], 2'b01, {8'h00, v[7:0]});
        addr = RES_BASE + 32'd5;
        emit(s_type(addr[11:0], 5'd1, 5'd0, 3'd0));
        expect_write(addr[16:1], 2'b10, {v[7:0], 8'h00});
        addr = RES_BASE + 32'd8;
        emit(s_type(addr[11:0], 5'd1, 5'd0, 3'd1));
        expect_write(addr[16:1], 2'b11, v[15:0]);
        addr = RES_BASE + 32'd12;
        emit(s_type(addr[11:0], 5'd1, 5'd0, 3'd2));
        expect_word(addr, v);
        emit(j_type(21'd0, 5'd0));
        wait_results("store_lane_cases");
        report_test("store_lane_cases");
    endtask

    task automatic load_extension();
        word_t       w;
        word_t       raw;
        logic [2:0]  f3;
        logic [11:0] off;
        reset_core();
        w = next_rand();
        ram[DATA_BASE[16:1]] = w[15:0];
        ram[DATA_BASE[16:1] + 16'd1] = w[31:16];
        for (int k = 0; k < 13; k++) begin
            if (k < 8) begin
                f3 = (k < 4) ? 3'd0 : 3'd4;
                off = 12'(k % 4);
            end else if (k < 12) begin
                f3 = (k < 10) ? 3'd1 : 3'd5;
                off = 12'(2 * (k % 2));
            end else begin
                f3 = 3'd2;
                off = 12'd0;
            end
            raw = w >> (8 * off);
            emit(i_type(DATA_BASE[11:0] + off, 5'd0, f3, 5'd9, OP_LOAD));
            store_result(5'd9, load_ext_ref(f3[1:0], f3[2], raw));
        end
        emit(j_type(21'd0, 5'd0));
        wait_results("load_extension");
        report_test("load_extension");
    endtask

    task automatic control_flow();
        word_t      a;
        word_t      b;
        word_t      p;
        logic [2:0] f3;
        reset_core();
        for (int r = 0; r < 2; r++) begin
            for (int k = 0; k < 6; k++) begin
                f3 = (k < 2) ? 3'(k) : 3'(k + 2);
                a = next_rand();
                b = (r == 0) ? next_rand() : a;
                load_const(5'd1, a);
                load_const(5'd2, b);
                // Marker is 1 when the branch skips the clear.
                emit(i_type(12'd1, 5'd0, 3'd0, 5'd5, OP_ALU_IMM));
                emit(b_type(13'd8, 5'd2, 5'd1, f3));
                emit(i_type(12'd0, 5'd0, 3'd0, 5'd5, OP_ALU_IMM));
                store_result(5'd5, {31'd0, branch_ref(f3, a, b)});
            end
        end
        p = asm_pc;
        emit(j_type(21'd8, 5'd6));
        emit_trap();
        store_result(5'd6, p + 32'd4);
        p = asm_pc + 32'd8;
        load_const(5'd8, p + 32'd3);
        emit(i_type(12'd5, 5'd8, 3'd0, 5'd7, OP_JALR));
        emit_trap();
        store_result(5'd7, p + 32'd4);
        a = next_rand();
        p = asm_pc;
        emit(u_type(a[31:12], 5'd10, OP_AUIPC));
        store_result(5'd10, p + {a[31:12], 12'h000});
        emit(j_type(21'd0, 5'd0));
        wait_results("control_flow");
        report_test("control_flow");
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        bus_in = 16'h0000;
        lcg_state = 32'h39a8;
        err_count = 0;
        check_count = 0;
        test_count = 0;
        reset_behavior();
        alu_sweep();
        store_lane_cases();
        load_extension();
        control_flow();
        err_count = err_count + uut.u_bus.u_bus_assert.violations;
        $display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
                 test_count, check_count, err_count, uut.u_bus.u_bus_assert.violations);
        if (err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
source/rv_pkg.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_bus_seq.sv
source/rv_core_ctrl.sv
source/rv_top.sv
dv/rv_bus_assert.sv
dv/rv_tb.sv
